//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [63:0]       mtime_t;

  // local device map, everything else is external memory
  localparam addr_t CLINT_MTIME_LO_ADDR = 32'ha000_0048;
  localparam addr_t CLINT_MTIME_HI_ADDR = 32'ha000_004c;
  localparam addr_t UART_TX_ADDR        = 32'ha000_03f8;

  // minimum spacing between two serial characters
  localparam int UART_CHAR_CYCLES = 16;
  localparam int UART_CNT_W       = $clog2(UART_CHAR_CYCLES);

  typedef logic [UART_CNT_W-1:0] uart_cnt_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_IFU_RD,
    ST_LSU_RD,
    ST_LSU_WR,
    ST_CLINT_RD,
    ST_UART_WR
  } arb_state_e;

endpackage

`default_nettype wire

//--- design/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import bus_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  ifu_arvalid_i,
  input  wire addr_t ifu_araddr_i,
  input  wire logic  lsu_arvalid_i,
  input  wire addr_t lsu_araddr_i,
  input  wire logic  lsu_awvalid_i,
  input  wire addr_t lsu_awaddr_i,
  input  wire data_t lsu_wdata_i,
  input  wire strb_t lsu_wstrb_i,
  input  wire logic  mem_done_i,
  input  wire logic  clint_done_i,
  input  wire logic  uart_done_i,
  input  wire data_t mem_rdata_i,
  input  wire data_t clint_rdata_i,
  output logic       mem_rd_start_o,
  output logic       mem_wr_start_o,
  output logic       clint_rd_start_o,
  output logic       uart_wr_start_o,
  output addr_t      req_addr_o,
  output data_t      req_wdata_o,
  output strb_t      req_wstrb_o,
  output data_t      ifu_rdata_o,
  output logic       ifu_rvalid_o,
  output data_t      lsu_rdata_o,
  output logic       lsu_rvalid_o,
  output logic       lsu_wready_o
);

  arb_state_e state_q;
  logic       xact_done;
  logic       lsu_rd_is_clint;
  logic       lsu_wr_is_uart;

  assign lsu_rd_is_clint = (lsu_araddr_i == CLINT_MTIME_LO_ADDR) ||
                           (lsu_araddr_i == CLINT_MTIME_HI_ADDR);
  assign lsu_wr_is_uart  = (lsu_awaddr_i == UART_TX_ADDR);

  // completion goes back only to the requester that owns the grant
  always_comb
  begin
    ifu_rvalid_o = (state_q == ST_IFU_RD) && mem_done_i;
    lsu_rvalid_o = ((state_q == ST_LSU_RD) && mem_done_i) ||
                   ((state_q == ST_CLINT_RD) && clint_done_i);
    lsu_wready_o = ((state_q == ST_LSU_WR) && mem_done_i) ||
                   ((state_q == ST_UART_WR) && uart_done_i);
    ifu_rdata_o  = (state_q == ST_IFU_RD) ? mem_rdata_i : '0;
    if (state_q == ST_CLINT_RD)
      lsu_rdata_o = clint_rdata_i;
    else if (state_q == ST_LSU_RD)
      lsu_rdata_o = mem_rdata_i;
    else
      lsu_rdata_o = '0;
  end

  assign xact_done = ifu_rvalid_o || lsu_rvalid_o || lsu_wready_o;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q          <= ST_IDLE;
      mem_rd_start_o   <= 1'b0;
      mem_wr_start_o   <= 1'b0;
      clint_rd_start_o <= 1'b0;
      uart_wr_start_o  <= 1'b0;
    end
    else
    begin
      mem_rd_start_o   <= 1'b0;
      mem_wr_start_o   <= 1'b0;
      clint_rd_start_o <= 1'b0;
      uart_wr_start_o  <= 1'b0;
      if (state_q == ST_IDLE)
      begin
        // store before load before fetch
        if (lsu_awvalid_i)
        begin
          state_q         <= lsu_wr_is_uart ? ST_UART_WR : ST_LSU_WR;
          uart_wr_start_o <= lsu_wr_is_uart;
          mem_wr_start_o  <= !lsu_wr_is_uart;
        end
        else if (lsu_arvalid_i)
        begin
          state_q          <= lsu_rd_is_clint ? ST_CLINT_RD : ST_LSU_RD;
          clint_rd_start_o <= lsu_rd_is_clint;
          mem_rd_start_o   <= !lsu_rd_is_clint;
        end
        else if (ifu_arvalid_i)
        begin
          state_q        <= ST_IFU_RD;
          mem_rd_start_o <= 1'b1;
        end
      end
      else if (xact_done)
        state_q <= ST_IDLE;
    end
  end

  // granted request is held for the whole transaction
  always_ff @(posedge clk)
  begin
    if (state_q == ST_IDLE)
    begin
      if (lsu_awvalid_i)
        req_addr_o <= lsu_awaddr_i;
      else if (lsu_arvalid_i)
        req_addr_o <= lsu_araddr_i;
      else
        req_addr_o <= ifu_araddr_i;
      req_wdata_o <= lsu_wdata_i;
      req_wstrb_o <= lsu_wstrb_i;
    end
  end

endmodule

`default_nettype wire

//--- design/mem_master.sv
`timescale 1ns/1ps
`default_nettype none

module mem_master import bus_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  rd_start_i,
  input  wire logic  wr_start_i,
  input  wire addr_t addr_i,
  input  wire data_t wdata_i,
  input  wire strb_t wstrb_i,
  output logic       mem_arvalid_o,
  output addr_t      mem_araddr_o,
  input  wire logic  mem_arready_i,
  input  wire logic  mem_rvalid_i,
  input  wire data_t mem_rdata_i,
  output logic       mem_awvalid_o,
  output addr_t      mem_awaddr_o,
  input  wire logic  mem_awready_i,
  output logic       mem_wvalid_o,
  output data_t      mem_wdata_o,
  output strb_t      mem_wstrb_o,
  input  wire logic  mem_wready_i,
  input  wire logic  mem_bvalid_i,
  output logic       done_o,
  output data_t      rdata_o
);

  logic rd_busy_q;
  logic wr_busy_q;
  logic rd_fire;
  logic wr_fire;

  assign rd_fire = rd_busy_q && mem_rvalid_i;
  // response only counts once both write channels have handshaked
  assign wr_fire = wr_busy_q && mem_bvalid_i && !mem_awvalid_o && !mem_wvalid_o;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_arvalid_o <= 1'b0;
      mem_awvalid_o <= 1'b0;
      mem_wvalid_o  <= 1'b0;
      rd_busy_q     <= 1'b0;
      wr_busy_q     <= 1'b0;
      done_o        <= 1'b0;
    end
    else
    begin
      if (rd_start_i)
        mem_arvalid_o <= 1'b1;
      else if (mem_arready_i)
        mem_arvalid_o <= 1'b0;

      // address and data channels drop independently
      if (wr_start_i)
        mem_awvalid_o <= 1'b1;
      else if (mem_awready_i)
        mem_awvalid_o <= 1'b0;
      if (wr_start_i)
        mem_wvalid_o <= 1'b1;
      else if (mem_wready_i)
        mem_wvalid_o <= 1'b0;

      if (rd_start_i)
        rd_busy_q <= 1'b1;
      else if (rd_fire)
        rd_busy_q <= 1'b0;
      if (wr_start_i)
        wr_busy_q <= 1'b1;
      else if (wr_fire)
        wr_busy_q <= 1'b0;

      done_o <= rd_fire || wr_fire;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_start_i)
      mem_araddr_o <= addr_i;
    if (wr_start_i)
    begin
      mem_awaddr_o <= addr_i;
      mem_wdata_o  <= wdata_i;
      mem_wstrb_o  <= wstrb_i;
    end
    if (rd_fire)
      rdata_o <= mem_rdata_i;
  end

endmodule

`default_nettype wire

//--- design/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer import bus_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  rd_start_i,
  input  wire addr_t addr_i,
  output logic       done_o,
  output data_t      rdata_o
);

  mtime_t mtime_q;
  data_t  hi_snap_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q   <= '0;
      hi_snap_q <= '0;
      done_o    <= 1'b0;
    end
    else
    begin
      mtime_q <= mtime_q + 64'd1;
      done_o  <= rd_start_i;
      // low read freezes the upper half for the following high read
      if (rd_start_i && (addr_i == CLINT_MTIME_LO_ADDR))
        hi_snap_q <= mtime_q[63:32];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_start_i)
    begin
      if (addr_i == CLINT_MTIME_LO_ADDR)
        rdata_o <= mtime_q[31:0];
      else
        rdata_o <= hi_snap_q;
    end
  end

endmodule

`default_nettype wire

//--- design/uart_tx_port.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_port import bus_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  wr_start_i,
  input  wire data_t wdata_i,
  input  wire strb_t wstrb_i,
  output logic       done_o,
  output logic       tx_valid_o,
  output logic [7:0] tx_data_o
);

  uart_cnt_t pace_cnt_q;
  logic      pend_q;
  logic      accept;
  logic      send_char;

  // write data stays stable from the arbiter while a write waits
  assign accept    = (wr_start_i || pend_q) && (pace_cnt_q == '0);
  assign send_char = accept && wstrb_i[0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pace_cnt_q <= '0;
      pend_q     <= 1'b0;
      done_o     <= 1'b0;
      tx_valid_o <= 1'b0;
    end
    else
    begin
      done_o     <= accept;
      tx_valid_o <= send_char;
      pend_q     <= (wr_start_i || pend_q) && !accept;
      if (send_char)
        pace_cnt_q <= uart_cnt_t'(UART_CHAR_CYCLES - 1);
      else if (pace_cnt_q != '0)
        pace_cnt_q <= pace_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (send_char)
      tx_data_o <= wdata_i[7:0];
  end

endmodule

`default_nettype wire

//--- design/bus_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module bus_subsystem import bus_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  ifu_arvalid_i,
  input  wire addr_t ifu_araddr_i,
  output data_t      ifu_rdata_o,
  output logic       ifu_rvalid_o,
  input  wire logic  lsu_arvalid_i,
  input  wire addr_t lsu_araddr_i,
  output data_t      lsu_rdata_o,
  output logic       lsu_rvalid_o,
  input  wire logic  lsu_awvalid_i,
  input  wire addr_t lsu_awaddr_i,
  input  wire data_t lsu_wdata_i,
  input  wire strb_t lsu_wstrb_i,
  output logic       lsu_wready_o,
  output logic       mem_arvalid_o,
  output addr_t      mem_araddr_o,
  input  wire logic  mem_arready_i,
  input  wire logic  mem_rvalid_i,
  input  wire data_t mem_rdata_i,
  output logic       mem_awvalid_o,
  output addr_t      mem_awaddr_o,
  input  wire logic  mem_awready_i,
  output logic       mem_wvalid_o,
  output data_t      mem_wdata_o,
  output strb_t      mem_wstrb_o,
  input  wire logic  mem_wready_i,
  input  wire logic  mem_bvalid_i,
  output logic       tx_valid_o,
  output logic [7:0] tx_data_o
);

  logic  mem_rd_start;
  logic  mem_wr_start;
  logic  clint_rd_start;
  logic  uart_wr_start;
  logic  mem_done;
  logic  clint_done;
  logic  uart_done;
  addr_t req_addr;
  data_t req_wdata;
  strb_t req_wstrb;
  data_t mem_rdata;
  data_t clint_rdata;

  bus_arbiter u_arbiter (
    .clk              (clk),
    .rst              (rst),
    .ifu_arvalid_i    (ifu_arvalid_i),
    .ifu_araddr_i     (ifu_araddr_i),
    .lsu_arvalid_i    (lsu_arvalid_i),
    .lsu_araddr_i     (lsu_araddr_i),
    .lsu_awvalid_i    (lsu_awvalid_i),
    .lsu_awaddr_i     (lsu_awaddr_i),
    .lsu_wdata_i      (lsu_wdata_i),
    .lsu_wstrb_i      (lsu_wstrb_i),
    .mem_done_i       (mem_done),
    .clint_done_i     (clint_done),
    .uart_done_i      (uart_done),
    .mem_rdata_i      (mem_rdata),
    .clint_rdata_i    (clint_rdata),
    .mem_rd_start_o   (mem_rd_start),
    .mem_wr_start_o   (mem_wr_start),
    .clint_rd_start_o (clint_rd_start),
    .uart_wr_start_o  (uart_wr_start),
    .req_addr_o       (req_addr),
    .req_wdata_o      (req_wdata),
    .req_wstrb_o      (req_wstrb),
    .ifu_rdata_o      (ifu_rdata_o),
    .ifu_rvalid_o     (ifu_rvalid_o),
    .lsu_rdata_o      (lsu_rdata_o),
    .lsu_rvalid_o     (lsu_rvalid_o),
    .lsu_wready_o     (lsu_wready_o)
  );

  mem_master u_mem_master (
    .clk           (clk),
    .rst           (rst),
    .rd_start_i    (mem_rd_start),
    .wr_start_i    (mem_wr_start),
    .addr_i        (req_addr),
    .wdata_i       (req_wdata),
    .wstrb_i       (req_wstrb),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arready_i (mem_arready_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_awvalid_o (mem_awvalid_o),
    .mem_awaddr_o  (mem_awaddr_o),
    .mem_awready_i (mem_awready_i),
    .mem_wvalid_o  (mem_wvalid_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_wstrb_o   (mem_wstrb_o),
    .mem_wready_i  (mem_wready_i),
    .mem_bvalid_i  (mem_bvalid_i),
    .done_o        (mem_done),
    .rdata_o       (mem_rdata)
  );

  clint_timer u_clint (
    .clk        (clk),
    .rst        (rst),
    .rd_start_i (clint_rd_start),
    .addr_i     (req_addr),
    .done_o     (clint_done),
    .rdata_o    (clint_rdata)
  );

  uart_tx_port u_uart (
    .clk        (clk),
    .rst        (rst),
    .wr_start_i (uart_wr_start),
    .wdata_i    (req_wdata),
    .wstrb_i    (req_wstrb),
    .done_o     (uart_done),
    .tx_valid_o (tx_valid_o),
    .tx_data_o  (tx_data_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // 8 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/bus_subsystem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module bus_subsystem_chk (
  input wire logic clk,
  input wire logic rst,
  input wire logic mem_arvalid_i,
  input wire logic mem_arready_i,
  input wire logic mem_awvalid_i,
  input wire logic mem_wvalid_i,
  input wire logic ifu_rvalid_i,
  input wire logic lsu_rvalid_i,
  input wire logic tx_valid_i
);

  int fail_cnt = 0;

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_i && !mem_arready_i |=> mem_arvalid_i)
    else
    begin
      fail_cnt++;
      $error("mem_arvalid_o dropped before mem_arready_i");
    end

  // one transaction at a time on the memory port
  rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(mem_arvalid_i && (mem_awvalid_i || mem_wvalid_i)))
    else
    begin
      fail_cnt++;
      $error("read and write valids high together");
    end

  rvalid_excl: assert property (@(posedge clk) disable iff (rst)
    !(ifu_rvalid_i && lsu_rvalid_i))
    else
    begin
      fail_cnt++;
      $error("ifu_rvalid_o and lsu_rvalid_o high together");
    end

  tx_single: assert property (@(posedge clk) disable iff (rst)
    tx_valid_i |=> !tx_valid_i)
    else
    begin
      fail_cnt++;
      $error("tx_valid_o high in two consecutive cycles");
    end

endmodule

`default_nettype wire

//--- testbench/tb_bus_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_subsystem import bus_pkg::*; ();

  localparam int    NUM_ITER  = 60;
  localparam int    NUM_BURST = 3;
  // an iteration issues up to two transactions
  localparam int    WDOG_CYC  = (2 * NUM_ITER + NUM_BURST) * (UART_CHAR_CYCLES + 8);
  localparam addr_t MEM_BASE  = 32'h0000_1000;

  logic       clk;
  logic       rst;
  logic       ifu_arvalid_i;
  addr_t      ifu_araddr_i;
  data_t      ifu_rdata_o;
  logic       ifu_rvalid_o;
  logic       lsu_arvalid_i;
  addr_t      lsu_araddr_i;
  data_t      lsu_rdata_o;
  logic       lsu_rvalid_o;
  logic       lsu_awvalid_i;
  addr_t      lsu_awaddr_i;
  data_t      lsu_wdata_i;
  strb_t      lsu_wstrb_i;
  logic       lsu_wready_o;
  logic       mem_arvalid_o;
  addr_t      mem_araddr_o;
  logic       mem_arready_i;
  logic       mem_rvalid_i;
  data_t      mem_rdata_i;
  logic       mem_awvalid_o;
  addr_t      mem_awaddr_o;
  logic       mem_awready_i;
  logic       mem_wvalid_o;
  data_t      mem_wdata_o;
  strb_t      mem_wstrb_o;
  logic       mem_wready_i;
  logic       mem_bvalid_i;
  logic       tx_valid_o;
  logic [7:0] tx_data_o;

  logic [31:0] lfsr_q = 32'h3979_27e7;
  int          errors = 0;
  longint      cycle_cnt;
  longint      last_tx_cycle = -1000;
  logic [7:0]  tx_expect[$];

  data_t ram[addr_t];
  data_t exp_mem[addr_t];

  // responder state
  int    ar_cnt = 0;
  int    r_cnt = 0;
  int    aw_cnt = 0;
  int    w_cnt = 0;
  int    b_cnt = 0;
  logic  rd_pend = 1'b0;
  logic  aw_got = 1'b0;
  logic  w_got = 1'b0;
  addr_t rd_addr;
  addr_t seen_awaddr;
  data_t seen_wdata;
  strb_t seen_wstrb;
  int    mem_wr_count = 0;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  bus_subsystem UUT (.*);

  bind bus_subsystem bus_subsystem_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .mem_arvalid_i (mem_arvalid_o),
    .mem_arready_i (mem_arready_i),
    .mem_awvalid_i (mem_awvalid_o),
    .mem_wvalid_i  (mem_wvalid_o),
    .ifu_rvalid_i  (ifu_rvalid_o),
    .lsu_rvalid_i  (lsu_rvalid_o),
    .tx_valid_i    (tx_valid_o)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // unwritten memory reads a pattern of the full address
  function automatic data_t fill_word(input addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h3c5a_a5c3;
  endfunction

  function automatic data_t strb_merge(input data_t old_w, input data_t new_w, input strb_t s);
    data_t r;
    r = old_w;
    for (int b = 0; b < STRB_W; b++)
      if (s[b])
        r[8*b +: 8] = new_w[8*b +: 8];
    return r;
  endfunction

  function automatic data_t model_word(input addr_t a);
    return exp_mem.exists(a) ? exp_mem[a] : fill_word(a);
  endfunction

  function automatic data_t ram_word(input addr_t a);
    return ram.exists(a) ? ram[a] : fill_word(a);
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic note_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  always @(posedge clk)
  begin
    if (rst)
      cycle_cnt <= 0;
    else
      cycle_cnt <= cycle_cnt + 1;
  end

  // memory responder, read side
  always @(posedge clk)
  begin
    mem_rvalid_i <= 1'b0;
    if (mem_arvalid_o && mem_arready_i)
    begin
      mem_arready_i <= 1'b0;
      rd_addr       <= mem_araddr_o;
      rd_pend       <= 1'b1;
      r_cnt         <= rand_bits(2);
      ar_cnt        <= rand_bits(2);
    end
    else if (mem_arvalid_o)
    begin
      if (ar_cnt == 0)
        mem_arready_i <= 1'b1;
      else
        ar_cnt <= ar_cnt - 1;
    end
    if (rd_pend)
    begin
      if (r_cnt == 0)
      begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= ram_word(rd_addr);
        rd_pend      <= 1'b0;
      end
      else
        r_cnt <= r_cnt - 1;
    end
  end

  // memory responder, write side
  always @(posedge clk)
  begin
    mem_bvalid_i <= 1'b0;
    if (mem_awvalid_o && mem_awready_i)
    begin
      mem_awready_i <= 1'b0;
      seen_awaddr   <= mem_awaddr_o;
      aw_got        <= 1'b1;
      aw_cnt        <= rand_bits(2);
    end
    else if (mem_awvalid_o)
    begin
      if (aw_cnt == 0)
        mem_awready_i <= 1'b1;
      else
        aw_cnt <= aw_cnt - 1;
    end
    if (mem_wvalid_o && mem_wready_i)
    begin
      mem_wready_i <= 1'b0;
      seen_wdata   <= mem_wdata_o;
      seen_wstrb   <= mem_wstrb_o;
      w_got        <= 1'b1;
      w_cnt        <= rand_bits(2);
    end
    else if (mem_wvalid_o)
    begin
      if (w_cnt == 0)
        mem_wready_i <= 1'b1;
      else
        w_cnt <= w_cnt - 1;
    end
    if (aw_got && w_got)
    begin
      if (b_cnt == 0)
      begin
        mem_bvalid_i     <= 1'b1;
        ram[seen_awaddr] = strb_merge(ram_word(seen_awaddr), seen_wdata, seen_wstrb);
        mem_wr_count++;
        aw_got           <= 1'b0;
        w_got            <= 1'b0;
        b_cnt            <= rand_bits(2);
      end
      else
        b_cnt <= b_cnt - 1;
    end
  end

  // serial output monitor
  always @(posedge clk)
  begin
    if (!rst && tx_valid_o)
    begin
      if (tx_expect.size() == 0)
        note_failure("unexpected character on tx_data_o");
      else if (tx_data_o != tx_expect[0])
        report_mismatch("tx_data_o", tx_data_o, tx_expect[0]);
      if (tx_expect.size() != 0)
        void'(tx_expect.pop_front());
      if (cycle_cnt - last_tx_cycle < UART_CHAR_CYCLES)
        note_failure("tx_valid_o pulses closer than the character spacing");
      last_tx_cycle = cycle_cnt;
    end
  end

  task automatic check_quiet_outputs();
    if ((mem_arvalid_o | mem_awvalid_o | mem_wvalid_o) !== 1'b0)
      note_failure("memory valid not low during or right after reset");
    if ((ifu_rvalid_o | lsu_rvalid_o | lsu_wready_o) !== 1'b0)
      note_failure("requester pulse not low during or right after reset");
    if (tx_valid_o !== 1'b0)
      note_failure("tx_valid_o not low during or right after reset");
  endtask

  task automatic store_word(input addr_t a, input data_t d, input strb_t s);
    int wr_before;
    wr_before = mem_wr_count;
    if (a == UART_TX_ADDR && s[0])
      tx_expect.push_back(d[7:0]);
    @(posedge clk);
    lsu_awvalid_i <= 1'b1;
    lsu_awaddr_i  <= a;
    lsu_wdata_i   <= d;
    lsu_wstrb_i   <= s;
    do
      @(posedge clk);
    while (!lsu_wready_o);
    lsu_awvalid_i <= 1'b0;
    if (a == UART_TX_ADDR)
    begin
      if (mem_wr_count != wr_before)
        note_failure("serial port store started a memory write");
    end
    else
    begin
      if (mem_wr_count != wr_before + 1)
        note_failure("memory store did not complete one memory write");
      if (seen_awaddr != a)
        report_mismatch("mem_awaddr_o", seen_awaddr, a);
      if (seen_wdata != d)
        report_mismatch("mem_wdata_o", seen_wdata, d);
      if (seen_wstrb != s)
        report_mismatch("mem_wstrb_o", seen_wstrb, s);
      exp_mem[a] = strb_merge(model_word(a), d, s);
    end
  endtask

  task automatic load_word(input addr_t a, output data_t d, output int lat);
    @(posedge clk);
    lsu_arvalid_i <= 1'b1;
    lsu_araddr_i  <= a;
    lat = 0;
    do
    begin
      @(posedge clk);
      lat++;
    end
    while (!lsu_rvalid_o);
    lsu_arvalid_i <= 1'b0;
    d = lsu_rdata_o;
  endtask

  task automatic fetch_word(input addr_t a);
    @(posedge clk);
    ifu_arvalid_i <= 1'b1;
    ifu_araddr_i  <= a;
    do
      @(posedge clk);
    while (!ifu_rvalid_o);
    ifu_arvalid_i <= 1'b0;
    if (ifu_rdata_o != model_word(a))
      report_mismatch("ifu_rdata_o", ifu_rdata_o, model_word(a));
  endtask

  task automatic verify_load(input addr_t a);
    data_t d;
    int    lat;
    load_word(a, d, lat);
    if (d != model_word(a))
      report_mismatch("lsu_rdata_o", d, model_word(a));
  endtask

  task automatic read_mtime_pair();
    data_t  lo;
    data_t  hi;
    int     lat;
    longint t0;
    longint t1;
    t0 = cycle_cnt + 1;
    load_word(CLINT_MTIME_LO_ADDR, lo, lat);
    t1 = cycle_cnt;
    // request seen in idle one edge after the drive, pulse two cycles later
    if (lat != 3)
      report_mismatch("clint lsu_rvalid_o latency", lat, 3);
    load_word(CLINT_MTIME_HI_ADDR, hi, lat);
    if ({hi, lo} < t0 || {hi, lo} > t1)
      note_failure($sformatf("mtime %0d outside cycle window %0d..%0d", {hi, lo}, t0, t1));
  endtask

  task automatic race_ifu_lsu(input addr_t ia, input addr_t la);
    logic got_ifu;
    logic got_lsu;
    got_ifu = 1'b0;
    got_lsu = 1'b0;
    @(posedge clk);
    ifu_arvalid_i <= 1'b1;
    ifu_araddr_i  <= ia;
    lsu_arvalid_i <= 1'b1;
    lsu_araddr_i  <= la;
    while (!(got_ifu && got_lsu))
    begin
      @(posedge clk);
      if (lsu_rvalid_o)
      begin
        got_lsu = 1'b1;
        lsu_arvalid_i <= 1'b0;
        if (lsu_rdata_o != model_word(la))
          report_mismatch("lsu_rdata_o", lsu_rdata_o, model_word(la));
      end
      if (ifu_rvalid_o)
      begin
        if (!got_lsu)
          note_failure("IFU completed before the LSU");
        got_ifu = 1'b1;
        ifu_arvalid_i <= 1'b0;
        if (ifu_rdata_o != model_word(ia))
          report_mismatch("ifu_rdata_o", ifu_rdata_o, model_word(ia));
      end
    end
  endtask

  function automatic addr_t window_addr();
    logic [31:0] r;
    r = rand_bits(3);
    return MEM_BASE + {r[29:0], 2'b00};
  endfunction

  initial
  begin
    int          kind;
    addr_t       a;
    addr_t       b;
    data_t       d;
    strb_t       s;
    logic [31:0] r;
    ifu_arvalid_i <= 1'b0;
    ifu_araddr_i  <= '0;
    lsu_arvalid_i <= 1'b0;
    lsu_araddr_i  <= '0;
    lsu_awvalid_i <= 1'b0;
    lsu_awaddr_i  <= '0;
    lsu_wdata_i   <= '0;
    lsu_wstrb_i   <= '0;
    mem_arready_i <= 1'b0;
    mem_rvalid_i  <= 1'b0;
    mem_rdata_i   <= '0;
    mem_awready_i <= 1'b0;
    mem_wready_i  <= 1'b0;
    mem_bvalid_i  <= 1'b0;

    // outputs checked at the falling edge while stable
    repeat (3)
    begin
      @(negedge clk);
      check_quiet_outputs();
    end

    for (int i = 0; i < NUM_ITER; i++)
    begin
      kind = rand_bits(3);
      a    = window_addr();
      b    = window_addr();
      // distinct addresses keep the two read words apart
      if (b == a)
        b = a ^ 32'h0000_0004;
      d    = rand_bits(32);
      r    = rand_bits(4);
      s    = r[3:0];
      case (kind)
        0, 1: fetch_word(a);
        2: store_word(a, d, s);
        3:
        begin
          store_word(a, d, s);
          verify_load(a);
        end
        4: verify_load(a);
        5: store_word(UART_TX_ADDR, d, s);
        6: read_mtime_pair();
        default: race_ifu_lsu(a, b);
      endcase
    end

    // back-to-back characters hit the pacing back-pressure
    for (int i = 0; i < NUM_BURST; i++)
    begin
      d = rand_bits(32);
      store_word(UART_TX_ADDR, d, 4'b0001);
    end

    // let the last character leave the port
    for (int n = 0; n < UART_CHAR_CYCLES && tx_expect.size() != 0; n++)
      @(posedge clk);
    if (tx_expect.size() != 0)
      note_failure("characters never appeared on tx_data_o");

    $display("errors: %0d, assertion failures: %0d", errors, UUT.u_chk.fail_cnt);
    if (errors == 0 && UUT.u_chk.fail_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, errors: %0d", WDOG_CYC, errors);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
design/bus_pkg.sv
design/bus_arbiter.sv
design/mem_master.sv
design/clint_timer.sv
design/uart_tx_port.sv
design/bus_subsystem.sv
testbench/tb_clk_gen.sv
testbench/bus_subsystem_chk.sv
testbench/tb_bus_subsystem.sv

//--- Bender.yml
package:
  name: bus_subsystem

sources:
  - design/bus_pkg.sv
  - design/bus_arbiter.sv
  - design/mem_master.sv
  - design/clint_timer.sv
  - design/uart_tx_port.sv
  - design/bus_subsystem.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/bus_subsystem_chk.sv
      - testbench/tb_bus_subsystem.sv
